// ==== source/snd_defines.svh ====
`ifndef SND_DEFINES_SVH
`define SND_DEFINES_SVH

// upper address nibble of the sound CPU map
`define SND_IO_PAGE     4'hF    // chip registers and latches
`define SND_RAM_PAGE    4'hD    // work RAM

// device select inside the I/O page, taken from A3..A1
`define SND_SEL_FM      3'd0
`define SND_SEL_OKI     3'd1
`define SND_SEL_BANK    3'd2    // ROM bank bit
`define SND_SEL_OKI7    3'd3    // ADPCM rate select
`define SND_SEL_LATCH0  3'd4
`define SND_SEL_LATCH1  3'd5

// fractional enables from the 48 MHz clock
// 48 * 63 / 845 gives about 3.58 MHz for FM and CPU
`define SND_FM_CEN_N    63
`define SND_FM_CEN_M    845

// 1 MHz for the ADPCM chip
`define SND_OKI_CEN_N   1
`define SND_OKI_CEN_M   48

// 2 KB work RAM
`define SND_RAM_AW      11

`endif

// ==== source/snd_bus_pkg.sv ====
package snd_bus_pkg;

    // sound CPU address bus
    typedef logic [15:0] cpu_addr_t;

    // CPU data byte, used for both directions and all read sources
    typedef logic [7:0] cpu_data_t;

    // program ROM address after banking
    // bit 15 marks the banked half
    typedef logic [15:0] rom_addr_t;

endpackage

// ==== source/snd_audio_pkg.sv ====
package snd_audio_pkg;

    typedef logic signed [15:0] fm_sample_t;     // full resolution FM output
    typedef logic signed [13:0] adpcm_sample_t;  // ADPCM decoder output

    // mixed channel sent off board
    typedef logic signed [15:0] mix_sample_t;

endpackage

// ==== source/snd_sel_if.sv ====
`timescale 1ns/100ps

interface snd_sel_if;

    logic rom_cs;     // program ROM read
    logic ram_cs;     // work RAM
    logic fm_cs;      // FM chip
    logic oki_cs;     // ADPCM chip
    logic latch0_cs;  // command latches from the main CPU
    logic latch1_cs;

    modport decoder (
        output rom_cs, ram_cs, fm_cs, oki_cs, latch0_cs, latch1_cs
    );

    // read data mux side
    modport reader (
        input rom_cs, ram_cs, fm_cs, oki_cs, latch0_cs, latch1_cs
    );

endinterface

// ==== source/snd_cen_gen.sv ====
`timescale 1ns/100ps
`include "snd_defines.svh"

module snd_cen_gen (
    input  logic clk,
    input  logic rst,
    output logic cen_fm,   // ~3.58 MHz
    output logic cen_fm2,  // half of cen_fm
    output logic cen_oki   // 1 MHz
);

    // FM fraction is the widest, so both accumulators share its width
    localparam int ACC_W = $clog2(`SND_FM_CEN_M + `SND_FM_CEN_N);

    localparam logic [ACC_W-1:0] FM_N  = ACC_W'(`SND_FM_CEN_N);
    localparam logic [ACC_W-1:0] FM_M  = ACC_W'(`SND_FM_CEN_M);
    localparam logic [ACC_W-1:0] OKI_N = ACC_W'(`SND_OKI_CEN_N);
    localparam logic [ACC_W-1:0] OKI_M = ACC_W'(`SND_OKI_CEN_M);

    logic [ACC_W-1:0] fm_acc;
    logic [ACC_W-1:0] oki_acc;
    logic [ACC_W:0]   fm_step;   // {wrap, next phase}
    logic [ACC_W:0]   oki_step;
    logic             fm_half;   // toggles on every cen_fm

    // add n, wrap at m
    function automatic logic [ACC_W:0] frac_step(
        input logic [ACC_W-1:0] acc,
        input logic [ACC_W-1:0] n,
        input logic [ACC_W-1:0] m
    );
        logic [ACC_W-1:0] sum;
        sum = acc + n;
        if (sum >= m)
            return {1'b1, sum - m};
        return {1'b0, sum};
    endfunction

    assign fm_step  = frac_step(fm_acc, FM_N, FM_M);
    assign oki_step = frac_step(oki_acc, OKI_N, OKI_M);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fm_acc  <= '0;
            oki_acc <= '0;
            fm_half <= 1'b0;
            cen_fm  <= 1'b0;
            cen_fm2 <= 1'b0;
            cen_oki <= 1'b0;
        end else begin
            fm_acc  <= fm_step[ACC_W-1:0];
            oki_acc <= oki_step[ACC_W-1:0];
            cen_fm  <= fm_step[ACC_W];
            cen_fm2 <= fm_step[ACC_W] & fm_half;  // lands on every second cen_fm
            cen_oki <= oki_step[ACC_W];
            if (fm_step[ACC_W])
                fm_half <= ~fm_half;
        end
    end

    // FM phase enable must coincide with the main FM enable
    a_fm2_in_fm: assert property (@(posedge clk) disable iff (rst) cen_fm2 |-> cen_fm)
        else $error("cen_fm2 high without cen_fm");

endmodule

// ==== source/snd_bus_decode.sv ====
`timescale 1ns/100ps
`include "snd_defines.svh"

module snd_bus_decode (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  cen_fm,
    input  snd_bus_pkg::cpu_addr_t cpu_addr,
    input  snd_bus_pkg::cpu_data_t cpu_dout,
    input  logic                  mreq_n,
    input  logic                  rd_n,
    input  logic                  wr_n,
    output snd_bus_pkg::rom_addr_t rom_addr,
    output logic                  fm_cs_n,
    output logic                  fm_wr_n,
    output logic                  oki_wr_n,
    output logic                  oki_ss,
    snd_sel_if.decoder            sel
);

    logic       io_cs;
    logic       rom_rd;
    logic [2:0] dev;      // A3..A1 inside the I/O page
    logic       bank;
    logic       bank_cs;
    logic       oki7_cs;

    assign io_cs  = !mreq_n && cpu_addr[15:12] == `SND_IO_PAGE;
    assign dev    = cpu_addr[3:1];
    // lower 32 KB plus the banked window at 8000-BFFF
    assign rom_rd = !mreq_n && !rd_n && (!cpu_addr[15] || cpu_addr[15:14] == 2'b10);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sel.rom_cs    <= 1'b0;
            sel.ram_cs    <= 1'b0;
            sel.fm_cs     <= 1'b0;
            sel.oki_cs    <= 1'b0;
            sel.latch0_cs <= 1'b0;
            sel.latch1_cs <= 1'b0;
            bank_cs       <= 1'b0;
            oki7_cs       <= 1'b0;
        end else begin
            sel.rom_cs    <= rom_rd;
            sel.ram_cs    <= !mreq_n && cpu_addr[15:12] == `SND_RAM_PAGE;
            sel.fm_cs     <= io_cs && dev == `SND_SEL_FM;
            sel.oki_cs    <= io_cs && dev == `SND_SEL_OKI;
            bank_cs       <= io_cs && dev == `SND_SEL_BANK;
            oki7_cs       <= io_cs && dev == `SND_SEL_OKI7;
            sel.latch0_cs <= io_cs && dev == `SND_SEL_LATCH0;
            sel.latch1_cs <= io_cs && dev == `SND_SEL_LATCH1;
        end
    end

    always_ff @(posedge clk) begin
        rom_addr <= cpu_addr[15] ? {1'b1, bank, cpu_addr[13:0]} : {1'b0, cpu_addr[14:0]};
    end

    // register writes only land on a CPU clock enable
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bank   <= 1'b0;
            oki_ss <= 1'b0;
        end else if (!wr_n && cen_fm) begin
            if (bank_cs)
                bank <= cpu_dout[0];
            if (oki7_cs)
                oki_ss <= cpu_dout[0];
        end
    end

    assign fm_cs_n  = ~sel.fm_cs;
    assign fm_wr_n  = wr_n | mreq_n;               // qualified write strobe
    assign oki_wr_n = ~(sel.oki_cs & ~fm_wr_n);

    a_sel_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot0({sel.rom_cs, sel.ram_cs, sel.fm_cs, sel.oki_cs,
                  bank_cs, oki7_cs, sel.latch0_cs, sel.latch1_cs}))
        else $error("more than one chip select active");

endmodule

// ==== source/snd_read_path.sv ====
`timescale 1ns/100ps
`include "snd_defines.svh"

module snd_read_path (
    input  logic                   clk,
    input  logic                   rst,
    snd_sel_if.reader              sel,
    input  snd_bus_pkg::cpu_addr_t cpu_addr,
    input  snd_bus_pkg::cpu_data_t cpu_dout,
    input  logic                   wr_n,
    input  logic                   mreq_n,
    input  snd_bus_pkg::cpu_data_t snd_latch0,
    input  snd_bus_pkg::cpu_data_t snd_latch1,
    input  snd_bus_pkg::cpu_data_t fm_dout,
    input  snd_bus_pkg::cpu_data_t oki_dout,
    input  snd_bus_pkg::cpu_data_t rom_data,
    input  logic                   rom_ok,
    output snd_bus_pkg::cpu_data_t cpu_din,
    output logic                   cpu_rom_ok
);

    snd_bus_pkg::cpu_data_t ram [0:(1 << `SND_RAM_AW)-1];
    snd_bus_pkg::cpu_data_t ram_dout;
    snd_bus_pkg::cpu_data_t cmd_latch;
    snd_bus_pkg::cpu_data_t dev_latch;
    snd_bus_pkg::cpu_data_t mem_latch;
    logic                   ram_we;
    logic                   latch_cs;
    logic                   dev_cs;
    logic                   mem_cs;
    logic                   rom_ok_d;  // rom_ok one cycle back

    assign ram_we = sel.ram_cs && !(wr_n | mreq_n);

    // work RAM, registered read
    always_ff @(posedge clk) begin
        if (ram_we)
            ram[cpu_addr[`SND_RAM_AW-1:0]] <= cpu_dout;
        ram_dout <= ram[cpu_addr[`SND_RAM_AW-1:0]];
    end

    // first stage picks inside each source group
    always_ff @(posedge clk) begin
        cmd_latch <= sel.latch0_cs ? snd_latch0 : snd_latch1;
        dev_latch <= sel.fm_cs ? fm_dout : oki_dout;
        mem_latch <= sel.ram_cs ? ram_dout : rom_data;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            latch_cs <= 1'b0;
            dev_cs   <= 1'b0;
            mem_cs   <= 1'b0;
            rom_ok_d <= 1'b0;
        end else begin
            latch_cs <= sel.latch0_cs | sel.latch1_cs;
            dev_cs   <= sel.fm_cs | sel.oki_cs;
            mem_cs   <= sel.ram_cs | sel.rom_cs;
            rom_ok_d <= rom_ok;
        end
    end

    // second stage, devices win over latches over memory
    always_ff @(posedge clk) begin
        if (dev_cs)
            cpu_din <= dev_latch;
        else if (latch_cs)
            cpu_din <= cmd_latch;
        else if (mem_cs)
            cpu_din <= mem_latch;
        else
            cpu_din <= 8'hFF;   // open bus
    end

    assign cpu_rom_ok = rom_ok & rom_ok_d;

endmodule

// ==== source/snd_mixer.sv ====
`timescale 1ns/100ps

module snd_mixer (
    input  logic                         clk,
    input  logic                         enable_fm,
    input  logic                         enable_adpcm,
    input  snd_audio_pkg::fm_sample_t    fm_left,
    input  snd_audio_pkg::fm_sample_t    fm_right,
    input  snd_audio_pkg::adpcm_sample_t adpcm_snd,
    output snd_audio_pkg::mix_sample_t   left,
    output snd_audio_pkg::mix_sample_t   right
);

    // one channel, no saturation
    function automatic snd_audio_pkg::mix_sample_t mix_chan(
        input logic                         en_fm,
        input logic                         en_pcm,
        input snd_audio_pkg::fm_sample_t    fm,
        input snd_audio_pkg::adpcm_sample_t pcm
    );
        snd_audio_pkg::mix_sample_t fm_part;
        snd_audio_pkg::mix_sample_t pcm_part;
        fm_part  = en_fm ? {fm[15], fm[15:1]} : '0;           // halve FM
        pcm_part = en_pcm ? {pcm[13], pcm, pcm[12]} : '0;     // 14 to 16 bits
        return fm_part + pcm_part;
    endfunction

    always_ff @(posedge clk) begin
        left  <= mix_chan(enable_fm, enable_adpcm, fm_left, adpcm_snd);
        right <= mix_chan(enable_fm, enable_adpcm, fm_right, adpcm_snd);
    end

endmodule

// ==== source/snd_top.sv ====
`timescale 1ns/100ps

module snd_top (
    input  logic                         clk,
    input  logic                         rst,
    // sound CPU bus
    input  snd_bus_pkg::cpu_addr_t       cpu_addr,
    input  snd_bus_pkg::cpu_data_t       cpu_dout,
    input  logic                         mreq_n,
    input  logic                         rd_n,
    input  logic                         wr_n,
    output snd_bus_pkg::cpu_data_t       cpu_din,
    output logic                         cpu_rom_ok,
    // commands from the main CPU
    input  snd_bus_pkg::cpu_data_t       snd_latch0,
    input  snd_bus_pkg::cpu_data_t       snd_latch1,
    // program ROM
    output snd_bus_pkg::rom_addr_t       rom_addr,
    output logic                         rom_cs,
    input  snd_bus_pkg::cpu_data_t       rom_data,
    input  logic                         rom_ok,
    // FM and ADPCM chip side
    input  snd_bus_pkg::cpu_data_t       fm_dout,
    input  snd_bus_pkg::cpu_data_t       oki_dout,
    output logic                         fm_cs_n,
    output logic                         fm_wr_n,
    output logic                         oki_wr_n,
    output logic                         oki_ss,
    output logic                         cen_fm,
    output logic                         cen_fm2,
    output logic                         cen_oki,
    // audio
    input  logic                         enable_fm,
    input  logic                         enable_adpcm,
    input  snd_audio_pkg::fm_sample_t    fm_left,
    input  snd_audio_pkg::fm_sample_t    fm_right,
    input  snd_audio_pkg::adpcm_sample_t adpcm_snd,
    input  logic                         fm_sample,  // new sample strobe from FM core
    output logic                         sample,
    output snd_audio_pkg::mix_sample_t   left,
    output snd_audio_pkg::mix_sample_t   right
);

    snd_sel_if sel ();

    assign rom_cs = sel.rom_cs;
    assign sample = fm_sample;

    snd_cen_gen i_cen (.clk, .rst, .cen_fm, .cen_fm2, .cen_oki);

    snd_bus_decode i_decode (
        .clk, .rst, .cen_fm, .cpu_addr, .cpu_dout, .mreq_n, .rd_n, .wr_n,
        .rom_addr, .fm_cs_n, .fm_wr_n, .oki_wr_n, .oki_ss, .sel(sel.decoder)
    );

    snd_read_path i_read (
        .clk, .rst, .sel(sel.reader), .cpu_addr, .cpu_dout, .wr_n, .mreq_n,
        .snd_latch0, .snd_latch1, .fm_dout, .oki_dout, .rom_data, .rom_ok,
        .cpu_din, .cpu_rom_ok
    );

    snd_mixer i_mixer (
        .clk, .enable_fm, .enable_adpcm, .fm_left, .fm_right, .adpcm_snd,
        .left, .right
    );

endmodule

// ==== tb/tb_snd_top.sv ====
`timescale 1ns/100ps
`include "snd_defines.svh"

module tb_snd_top;

    localparam int CLK_PERIOD    = 40;
    localparam int ENABLE_CYCLES = 3380;
    localparam int BUS_CYCLES    = 400;   // upper bound of the bus sequence
    localparam int MIXER_CYCLES  = 200;
    localparam int WATCHDOG_NS   = (4 + ENABLE_CYCLES + BUS_CYCLES + MIXER_CYCLES + 500)
                                   * CLK_PERIOD;

    logic clk, rst;
    snd_bus_pkg::cpu_addr_t cpu_addr;
    snd_bus_pkg::cpu_data_t cpu_dout, cpu_din, snd_latch0, snd_latch1;
    snd_bus_pkg::cpu_data_t rom_data, fm_dout, oki_dout;
    snd_bus_pkg::rom_addr_t rom_addr;
    logic mreq_n, rd_n, wr_n, rom_ok, cpu_rom_ok, rom_cs;
    logic fm_cs_n, fm_wr_n, oki_wr_n, oki_ss, cen_fm, cen_fm2, cen_oki;
    logic enable_fm, enable_adpcm, fm_sample, sample;
    snd_audio_pkg::fm_sample_t    fm_left, fm_right;
    snd_audio_pkg::adpcm_sample_t adpcm_snd;
    snd_audio_pkg::mix_sample_t   left, right;

    int errors = 0;
    int n_access = 0;
    logic rd_check;                        // read data expected to be settled
    logic [7:0] ram_model [0:2047];
    logic io_page, exp_rom_rd, m_bank, m_oki_ss, oki_seen;
    logic q_fm, q_oki, q_rom, q_bank, q_oki7, q_rom_ok;
    logic [2:0] dev;
    logic [15:0] exp_rom_addr, q_rom_addr, exp_left_q, exp_right_q;
    logic [7:0] exp_din;
    int oki_gap;

    snd_top i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // expected decode from the address map
    assign dev          = cpu_addr[3:1];
    assign io_page      = !mreq_n && cpu_addr[15:12] == `SND_IO_PAGE;
    assign exp_rom_rd   = !mreq_n && !rd_n && cpu_addr < 16'hC000;
    assign exp_rom_addr = cpu_addr[15] ? {1'b1, m_bank, cpu_addr[13:0]} : cpu_addr;

    always_comb begin
        if (io_page && dev == `SND_SEL_FM)           exp_din = fm_dout;
        else if (io_page && dev == `SND_SEL_OKI)     exp_din = oki_dout;
        else if (io_page && dev == `SND_SEL_LATCH0)  exp_din = snd_latch0;
        else if (io_page && dev == `SND_SEL_LATCH1)  exp_din = snd_latch1;
        else if (!mreq_n && cpu_addr[15:12] == `SND_RAM_PAGE) exp_din = ram_model[cpu_addr[10:0]];
        else if (exp_rom_rd)                         exp_din = rom_data;
        else                                         exp_din = 8'hFF;
    end

    // FM halved, ADPCM doubled plus its bit 12, disabled source is zero
    function automatic logic [15:0] scaled_sum(input logic en_fm, input logic en_pcm,
                                               input logic signed [15:0] fm,
                                               input logic signed [13:0] pcm);
        int acc;
        acc = 0;
        if (en_fm)
            acc = acc + (int'(fm) >>> 1);
        if (en_pcm)
            acc = acc + int'(pcm) * 2 + int'(pcm[12]);
        return acc[15:0];
    endfunction

    always @(posedge clk) begin
        q_fm        <= io_page && dev == `SND_SEL_FM;
        q_oki       <= io_page && dev == `SND_SEL_OKI;
        q_bank      <= io_page && dev == `SND_SEL_BANK;
        q_oki7      <= io_page && dev == `SND_SEL_OKI7;
        q_rom       <= exp_rom_rd;
        q_rom_addr  <= exp_rom_addr;
        q_rom_ok    <= rom_ok;
        exp_left_q  <= scaled_sum(enable_fm, enable_adpcm, fm_left, adpcm_snd);
        exp_right_q <= scaled_sum(enable_fm, enable_adpcm, fm_right, adpcm_snd);
    end

    // bank and rate select land only on a CPU enable
    always @(posedge clk or posedge rst) begin
        if (rst) begin
            m_bank   <= 1'b0;
            m_oki_ss <= 1'b0;
            oki_seen <= 1'b0;
            oki_gap  <= 0;
        end else begin
            if (!wr_n && cen_fm && q_bank) m_bank <= cpu_dout[0];
            if (!wr_n && cen_fm && q_oki7) m_oki_ss <= cpu_dout[0];
            oki_seen <= oki_seen | cen_oki;
            oki_gap  <= cen_oki ? 1 : oki_gap + 1;   // cycles since last ADPCM enable
        end
    end

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        errors++;
        $display("ERR %s: expected %0h, actual %0h", name, expected, actual);
    endtask

    a_fm_cs: assert property (@(posedge clk) disable iff (rst) fm_cs_n == !q_fm)
        else report_mismatch("fm_cs_n", $sampled(!q_fm), $sampled(fm_cs_n));
    a_fm_wr: assert property (@(posedge clk) disable iff (rst)
        fm_wr_n == !(!wr_n && !mreq_n))
        else report_mismatch("fm_wr_n", $sampled(!(!wr_n && !mreq_n)), $sampled(fm_wr_n));
    a_oki_wr: assert property (@(posedge clk) disable iff (rst)
        oki_wr_n == !(q_oki && !wr_n && !mreq_n))
        else report_mismatch("oki_wr_n", $sampled(!(q_oki && !wr_n && !mreq_n)),
                             $sampled(oki_wr_n));
    a_rom_cs: assert property (@(posedge clk) disable iff (rst) rom_cs == q_rom)
        else report_mismatch("rom_cs", $sampled(q_rom), $sampled(rom_cs));
    a_rom_addr: assert property (@(posedge clk) disable iff (rst) q_rom |-> rom_addr == q_rom_addr)
        else report_mismatch("rom_addr", $sampled(q_rom_addr), $sampled(rom_addr));
    a_oki_ss: assert property (@(posedge clk) disable iff (rst) oki_ss == m_oki_ss)
        else report_mismatch("oki_ss", $sampled(m_oki_ss), $sampled(oki_ss));
    a_oki_period: assert property (@(posedge clk) disable iff (rst)
        (cen_oki && oki_seen) |-> oki_gap == `SND_OKI_CEN_M / `SND_OKI_CEN_N)
        else report_mismatch("cen_oki period", 48, $sampled(oki_gap));
    a_oki_missing: assert property (@(posedge clk) disable iff (rst) oki_seen |-> oki_gap <= 48)
        else report_mismatch("cen_oki gap", 48, $sampled(oki_gap));
    a_din: assert property (@(posedge clk) disable iff (rst) rd_check |-> cpu_din == exp_din)
        else report_mismatch("cpu_din", $sampled(exp_din), $sampled(cpu_din));
    a_left: assert property (@(posedge clk) disable iff (rst) left == exp_left_q)
        else report_mismatch("mixer left", $sampled(exp_left_q), $sampled(left));
    a_right: assert property (@(posedge clk) disable iff (rst) right == exp_right_q)
        else report_mismatch("mixer right", $sampled(exp_right_q), $sampled(right));
    a_ready: assert property (@(posedge clk) disable iff (rst) cpu_rom_ok == (rom_ok && q_rom_ok))
        else report_mismatch("cpu_rom_ok", $sampled(rom_ok && q_rom_ok), $sampled(cpu_rom_ok));
    a_sample: assert property (@(posedge clk) sample == fm_sample)
        else report_mismatch("sample", $sampled(fm_sample), $sampled(sample));

    // one CPU access, held like the real CPU between enables
    task automatic bus_access(input logic [15:0] addr, input logic [7:0] data,
                              input logic write, input int hold);
        snd_latch0 = 8'($urandom);
        snd_latch1 = 8'($urandom);
        fm_dout    = 8'($urandom);
        oki_dout   = 8'($urandom);
        rom_data   = 8'($urandom);
        cpu_addr   = addr;
        cpu_dout   = data;
        mreq_n     = 1'b0;
        rd_n       = write;
        wr_n       = !write;
        if (write && addr[15:12] == `SND_RAM_PAGE)
            ram_model[addr[10:0]] = data;
        repeat (3) begin
            @(posedge clk);
            #2;
        end
        rd_check = !write;       // read data settles three cycles after the address
        repeat (hold) begin
            @(posedge clk);
            #2;
        end
        rd_check = 1'b0;
        mreq_n   = 1'b1;
        rd_n     = 1'b1;
        wr_n     = 1'b1;
        @(posedge clk);
        #2;
        n_access++;
    endtask

    task automatic exercise_bus();
        int i;
        logic b;
        logic [15:0] ram_addr [8];
        for (i = 0; i < 8; i++)
            bus_access(16'hF000 | 16'(i << 1), 8'h00, 1'b0, 1);   // 6 and 7 are open bus
        bus_access(16'hF000, 8'($urandom), 1'b1, 1);
        bus_access(16'hF002, 8'($urandom), 1'b1, 1);
        for (i = 0; i < 3; i++) begin
            b = !i[0];
            bus_access(16'hF004, {7'($urandom), b}, 1'b1, 16);
            bus_access(16'h8000 | 16'($urandom & 32'h3FFF), 8'h00, 1'b0, 1);
            bus_access(16'($urandom & 32'h7FFF), 8'h00, 1'b0, 1);
        end
        bus_access(16'hF004, 8'h00, 1'b1, 1);   // short write, may miss the enable
        bus_access(16'h8000 | 16'($urandom & 32'h3FFF), 8'h00, 1'b0, 1);
        bus_access(16'hF006, 8'h01, 1'b1, 16);
        bus_access(16'hF006, 8'h00, 1'b1, 16);
        for (i = 0; i < 8; i++) begin
            ram_addr[i] = 16'hD000 | 16'($urandom & 32'h07FF);
            bus_access(ram_addr[i], 8'($urandom), 1'b1, 1);
        end
        for (i = 0; i < 8; i++)
            bus_access(ram_addr[i], 8'h00, 1'b0, 1);
        bus_access(16'hE123, 8'h00, 1'b0, 1);
        bus_access(16'hC456, 8'h00, 1'b0, 1);
    endtask

    task automatic sweep_mixer();
        int i;
        for (i = 0; i < MIXER_CYCLES; i++) begin
            {enable_adpcm, enable_fm} = 2'(i);
            fm_left   = 16'($urandom);
            fm_right  = 16'($urandom);
            adpcm_snd = 14'($urandom);
            fm_sample = i[2];
            rom_ok    = ($urandom & 3) != 0;
            @(posedge clk);
            #2;
        end
    endtask

    task automatic count_enables();
        int fm_n;
        int fm2_n;
        int oki_n;
        int exp_fm;
        int exp_oki;
        fm_n    = 0;
        fm2_n   = 0;
        oki_n   = 0;
        exp_fm  = ENABLE_CYCLES * `SND_FM_CEN_N / `SND_FM_CEN_M;
        exp_oki = ENABLE_CYCLES * `SND_OKI_CEN_N / `SND_OKI_CEN_M;
        repeat (ENABLE_CYCLES) begin
            @(negedge clk);
            fm_n  += int'(cen_fm);
            fm2_n += int'(cen_fm2);
            oki_n += int'(cen_oki);
        end
        assert (fm_n >= exp_fm - 1 && fm_n <= exp_fm + 1)
            else report_mismatch("cen_fm count", exp_fm, fm_n);
        assert (fm2_n >= exp_fm / 2 - 1 && fm2_n <= exp_fm / 2 + 1)
            else report_mismatch("cen_fm2 count", exp_fm / 2, fm2_n);
        assert (oki_n >= exp_oki - 1 && oki_n <= exp_oki + 1)
            else report_mismatch("cen_oki count", exp_oki, oki_n);
    endtask

    initial begin
        void'($urandom(85));
        rst = 1'b1;
        cpu_addr = '0;
        cpu_dout = '0;
        mreq_n = 1'b1;
        rd_n = 1'b1;
        wr_n = 1'b1;
        {snd_latch0, snd_latch1, rom_data, fm_dout, oki_dout} = '0;
        rom_ok = 1'b0;
        rd_check = 1'b0;
        {enable_fm, enable_adpcm, fm_sample} = '0;
        fm_left = '0;
        fm_right = '0;
        adpcm_snd = '0;
        repeat (4) @(posedge clk);
        #2 rst = 1'b0;
        fork
            count_enables();
            exercise_bus();
            sweep_mixer();
        join
        $display("run complete: %0d bus accesses, %0d errors", n_access, errors);
        if (errors == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before the tests finished");
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+source
source/snd_bus_pkg.sv
source/snd_audio_pkg.sv
source/snd_sel_if.sv
source/snd_cen_gen.sv
source/snd_bus_decode.sv
source/snd_read_path.sv
source/snd_mixer.sv
source/snd_top.sv
tb/tb_snd_top.sv

// ==== Makefile ====
# Verilator build and run of the sound board testbench

VERILATOR ?= verilator
TOP       ?= tb_snd_top
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench, fail unless it passes"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "ALL TESTS PASSED"

clean:
	rm -rf $(BUILD_DIR)
